// ==== mif_reconfig.f ====
source/mif_ctrl_pkg.sv
source/dprio_req_if.sv
source/mif_ctrl_regs.sv
source/mif_stream_engine.sv
source/user_direct_engine.sv
source/dprio_arbiter.sv
source/dprio_rmw_access.sv
source/mif_reconfig_ctrl.sv
tests/mif_reconfig_checker.sv
tests/mif_reconfig_ctrl_tb.sv

// ==== source/dprio_arbiter.sv ====
// round-robin arbiter between the stream and direct engines
// grant held from acceptance until the response, no added latency
`timescale 1ns/1ns
`default_nettype none

module dprio_arbiter (
    input  wire             clk,
    input  wire             reset,
    dprio_req_if.server     stream_bus,
    dprio_req_if.server     direct_bus,
    dprio_req_if.requester  access_bus
);

    logic busy;          // transaction in flight
    logic owner;         // 1 = direct engine holds the grant
    logic prio_direct;   // direct engine wins the next tie
    logic pick;
    logic sel;

    assign pick = direct_bus.req_valid && (!stream_bus.req_valid || prio_direct);
    assign sel  = busy ? owner : pick;

    assign access_bus.req_valid = sel ? direct_bus.req_valid : stream_bus.req_valid;
    assign access_bus.write     = sel ? direct_bus.write     : stream_bus.write;
    assign access_bus.protect   = sel ? direct_bus.protect   : stream_bus.protect;
    assign access_bus.addr      = sel ? direct_bus.addr      : stream_bus.addr;
    assign access_bus.wdata     = sel ? direct_bus.wdata     : stream_bus.wdata;

    assign stream_bus.req_ready = !busy && !sel && access_bus.req_ready;
    assign direct_bus.req_ready = !busy && sel && access_bus.req_ready;

    // response goes back only to the owner
    assign stream_bus.rsp_valid = busy && !owner && access_bus.rsp_valid;
    assign direct_bus.rsp_valid = busy && owner && access_bus.rsp_valid;
    assign stream_bus.rdata     = access_bus.rdata;
    assign direct_bus.rdata     = access_bus.rdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            prio_direct <= 1'b0;
        end else if (!busy && access_bus.req_valid && access_bus.req_ready) begin
            busy        <= 1'b1;
            owner       <= pick;
            prio_direct <= !pick;   // other side first next time
        end else if (busy && access_bus.rsp_valid) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/dprio_req_if.sv ====
// register space request/response channel
// one request in flight, exactly one response pulse per request
`timescale 1ns/1ns
`default_nettype none

interface dprio_req_if
    import mif_ctrl_pkg::*;
();

    logic        req_valid;
    logic        req_ready;
    logic        write;
    logic        protect;     // apply read-modify-write masking
    dprio_addr_t addr;
    dprio_data_t wdata;
    logic        rsp_valid;
    dprio_data_t rdata;       // meaningful for reads only

    modport requester (
        output req_valid, write, protect, addr, wdata,
        input  req_ready, rsp_valid, rdata
    );

    modport server (
        input  req_valid, write, protect, addr, wdata,
        output req_ready, rsp_valid, rdata
    );

endinterface

`default_nettype wire

// ==== source/dprio_rmw_access.sv ====
// register space access unit
// plain reads and writes, read-modify-write for addresses with protected bits
`timescale 1ns/1ns
`default_nettype none

module dprio_rmw_access
    import mif_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    dprio_req_if.server     bus,
    output logic            dprio_go,
    output logic            dprio_write,
    output dprio_addr_t     dprio_addr,
    output dprio_data_t     dprio_wdata,
    input  wire             dprio_wait,
    input  dprio_data_t     dprio_rdata
);

    typedef enum logic [2:0] {
        A_IDLE,
        A_READ,    // go strobe for a read
        A_WRITE,   // go strobe for a write
        A_WAIT,
        A_RESP
    } acc_state_t;

    acc_state_t  state;
    logic        write_q;
    logic        wr_phase;      // current access is the write
    dprio_addr_t addr_q;
    dprio_data_t wdata_q;
    dprio_data_t mask_q;
    dprio_data_t saved_q;       // last data read back
    dprio_data_t lookup_mask;
    logic        plain_write;

    function automatic dprio_data_t mask_of(input dprio_addr_t a);
        dprio_data_t m;
        m = '0;   // unlisted addresses are fully writable
        for (int i = 0; i < RMW_NUM; i++) begin
            if (a == RMW_ADDR[i]) begin
                m = RMW_MASK[i];
            end
        end
        return m;
    endfunction

    assign lookup_mask = (bus.write && bus.protect) ? mask_of(bus.addr) : '0;
    assign plain_write = bus.write && (lookup_mask == '0);

    assign bus.req_ready = (state == A_IDLE);
    assign bus.rsp_valid = (state == A_RESP);
    assign bus.rdata     = saved_q;

    assign dprio_go    = (state == A_READ) || (state == A_WRITE);
    assign dprio_write = wr_phase;
    assign dprio_addr  = addr_q;
    // keep masked bits from the register, take the rest from the request
    assign dprio_wdata = (saved_q & mask_q) | (wdata_q & ~mask_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= A_IDLE;
            write_q  <= 1'b0;
            wr_phase <= 1'b0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (bus.req_valid) begin
                        write_q  <= bus.write;
                        wr_phase <= plain_write;
                        state    <= plain_write ? A_WRITE : A_READ;
                    end
                end
                A_READ, A_WRITE: state <= A_WAIT;
                A_WAIT: begin
                    if (!dprio_wait) begin
                        if (write_q && !wr_phase) begin   // read half of an RMW done
                            wr_phase <= 1'b1;
                            state    <= A_WRITE;
                        end else begin
                            state <= A_RESP;
                        end
                    end
                end
                A_RESP: begin
                    wr_phase <= 1'b0;
                    state    <= A_IDLE;
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == A_IDLE) && bus.req_valid) begin
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
            mask_q  <= lookup_mask;
        end
        if ((state == A_WAIT) && !dprio_wait && !wr_phase) begin
            saved_q <= dprio_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/mif_ctrl_pkg.sv ====
// MIF reconfiguration controller shared definitions
// widths, user modes, local register map, error bits and protected-address table
`default_nettype none

package mif_ctrl_pkg;

    // register space side
    typedef logic [11:0] dprio_addr_t;
    typedef logic [15:0] dprio_data_t;

    // user port side
    typedef logic [11:0] uif_addr_t;
    typedef logic [31:0] uif_data_t;

    typedef logic [31:0] mif_base_t;   // MIF image base handed to the fetcher

    // user access modes, code 3 is not assigned
    typedef enum logic [1:0] {
        MODE_STREAM = 2'd0,   // local stream registers
        MODE_DIRECT = 2'd1,   // single access with read-modify-write
        MODE_RAW    = 2'd2    // single access, no protection
    } mif_mode_t;

    // error status
    typedef logic [1:0] mif_err_t;
    localparam int ERR_BAD_OFFSET = 0;
    localparam int ERR_STRAY_WORD = 1;

    // stream mode register offsets
    localparam uif_addr_t REG_BASE_OFST = 12'd0;
    localparam uif_addr_t REG_CTRL_OFST = 12'd1;
    localparam uif_addr_t REG_ERR_OFST  = 12'd2;   // last legal offset

    // control register bits, both self-clearing
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    // addresses holding bits that a write must not disturb
    localparam int RMW_NUM = 4;

    localparam dprio_addr_t RMW_ADDR [RMW_NUM] = '{
        12'h010,
        12'h024,
        12'h03A,
        12'h061
    };

    // a 1 keeps the bit currently in the register
    localparam dprio_data_t RMW_MASK [RMW_NUM] = '{
        16'h00F0,
        16'h8000,
        16'h0307,
        16'hFF00
    };

endpackage

`default_nettype wire

// ==== source/mif_ctrl_regs.sv ====
// stream mode local registers
// MIF base address, start/clear control and the error status register
`timescale 1ns/1ns
`default_nettype none

module mif_ctrl_regs
    import mif_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        req_valid,
    input  wire        write,
    input  uif_addr_t  addr,
    input  uif_data_t  wdata,
    output logic       rsp_valid,
    output uif_data_t  rdata,
    input  wire        stray_word,
    output logic       start,
    output mif_base_t  base_addr
);

    logic     [1:0] ctrl_q;     // start and clear, high for one cycle
    mif_err_t       err;
    logic           ctrl_wr;
    logic           clear_now;
    logic           bad_ofst;

    assign ctrl_wr   = req_valid && write && (addr == REG_CTRL_OFST);
    assign clear_now = ctrl_wr && wdata[CTRL_CLEAR_BIT];
    assign bad_ofst  = req_valid && (addr > REG_ERR_OFST);
    assign start     = ctrl_q[CTRL_START_BIT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            base_addr <= '0;
            ctrl_q    <= 2'b00;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;   // always answers next cycle
            ctrl_q    <= ctrl_wr ? wdata[1:0] : 2'b00;
            if (req_valid && write && (addr == REG_BASE_OFST)) begin
                base_addr <= mif_base_t'(wdata);
            end
        end
    end

    // clear beats any error raised in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            err <= '0;
        end else if (clear_now) begin
            err <= '0;
        end else begin
            if (bad_ofst) begin
                err[ERR_BAD_OFFSET] <= 1'b1;
            end
            if (stray_word) begin
                err[ERR_STRAY_WORD] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            case (addr)
                REG_BASE_OFST: rdata <= uif_data_t'(base_addr);
                REG_CTRL_OFST: rdata <= uif_data_t'(ctrl_q);
                REG_ERR_OFST:  rdata <= uif_data_t'(err);
                default:       rdata <= '0;   // illegal offset
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/mif_reconfig_ctrl.sv ====
// MIF reconfiguration controller top level
// steers user requests by mode, stream and direct engines share the access unit
`timescale 1ns/1ns
`default_nettype none

module mif_reconfig_ctrl
    import mif_ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          uif_valid,
    output logic         uif_ready,
    input  wire          uif_write,
    input  mif_mode_t    uif_mode,
    input  uif_addr_t    uif_addr,
    input  uif_data_t    uif_wdata,
    output logic         uif_rsp_valid,
    output uif_data_t    uif_rdata,
    input  wire          mif_valid,
    output logic         mif_ready,
    input  dprio_addr_t  mif_addr,
    input  dprio_data_t  mif_data,
    input  wire          mif_last,
    output logic         mif_start,
    output mif_base_t    mif_base_addr,
    output logic         dprio_go,
    output logic         dprio_write,
    output dprio_addr_t  dprio_addr,
    output dprio_data_t  dprio_wdata,
    input  wire          dprio_wait,
    input  dprio_data_t  dprio_rdata
);

    logic      is_raw, is_direct, is_stream;
    logic      regs_rsp_valid, direct_rsp_valid, direct_ready;
    logic      stray_word;
    logic      bad_mode_q;   // last register access came in on the unused code
    uif_data_t regs_rdata, direct_rdata;

    dprio_req_if stream_bus ();
    dprio_req_if direct_bus ();
    dprio_req_if access_bus ();

    assign is_raw    = (uif_mode == MODE_RAW);
    assign is_direct = (uif_mode == MODE_DIRECT);
    assign is_stream = !(is_raw || is_direct);   // invalid code lands here too

    assign uif_ready     = is_stream || direct_ready;
    assign uif_rsp_valid = regs_rsp_valid || direct_rsp_valid;
    assign uif_rdata     = regs_rsp_valid ? (bad_mode_q ? '0 : regs_rdata) : direct_rdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bad_mode_q <= 1'b0;
        end else if (uif_valid && is_stream) begin
            bad_mode_q <= (uif_mode != MODE_STREAM);
        end
    end

    mif_ctrl_regs mif_ctrl_regs_inst (
        .clk(clk), .reset(reset), .req_valid(uif_valid && is_stream), .write(uif_write),
        .addr(uif_addr), .wdata(uif_wdata), .rsp_valid(regs_rsp_valid), .rdata(regs_rdata),
        .stray_word(stray_word), .start(mif_start), .base_addr(mif_base_addr)
    );

    mif_stream_engine mif_stream_engine_inst (
        .clk(clk), .reset(reset), .start(mif_start), .mif_valid(mif_valid),
        .mif_ready(mif_ready), .mif_addr(mif_addr), .mif_data(mif_data),
        .mif_last(mif_last), .stray_word(stray_word), .bus(stream_bus)
    );

    user_direct_engine user_direct_engine_inst (
        .clk(clk), .reset(reset), .req_valid(uif_valid && !is_stream),
        .req_ready(direct_ready), .write(uif_write), .raw(is_raw), .addr(uif_addr),
        .wdata(uif_wdata), .rsp_valid(direct_rsp_valid), .rdata(direct_rdata),
        .bus(direct_bus)
    );

    dprio_arbiter dprio_arbiter_inst (
        .clk(clk), .reset(reset), .stream_bus(stream_bus), .direct_bus(direct_bus),
        .access_bus(access_bus)
    );

    dprio_rmw_access dprio_rmw_access_inst (
        .clk(clk), .reset(reset), .bus(access_bus), .dprio_go(dprio_go),
        .dprio_write(dprio_write), .dprio_addr(dprio_addr), .dprio_wdata(dprio_wdata),
        .dprio_wait(dprio_wait), .dprio_rdata(dprio_rdata)
    );

endmodule

`default_nettype wire

// ==== source/mif_stream_engine.sv ====
// MIF stream engine
// armed by start, turns each MIF word into a protected register write
`timescale 1ns/1ns
`default_nettype none

module mif_stream_engine
    import mif_ctrl_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire                     mif_valid,
    output logic                    mif_ready,
    input  dprio_addr_t             mif_addr,
    input  dprio_data_t             mif_data,
    input  wire                     mif_last,
    output logic                    stray_word,
    dprio_req_if.requester          bus
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ARMED,
        S_WAIT     // write outstanding
    } strm_state_t;

    strm_state_t state;
    logic        last_q;

    // idle swallows words so the source never stalls
    assign mif_ready  = (state == S_IDLE) || ((state == S_ARMED) && bus.req_ready);
    assign stray_word = (state == S_IDLE) && mif_valid;

    // word goes straight onto the bus, source holds it until ready
    assign bus.req_valid = (state == S_ARMED) && mif_valid;
    assign bus.write     = 1'b1;
    assign bus.protect   = 1'b1;
    assign bus.addr      = mif_addr;
    assign bus.wdata     = mif_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= S_IDLE;
            last_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_ARMED;
                    end
                end
                S_ARMED: begin
                    if (mif_valid && bus.req_ready) begin
                        last_q <= mif_last;
                        state  <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (bus.rsp_valid) begin
                        state <= last_q ? S_IDLE : S_ARMED;   // disarm after last word
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/user_direct_engine.sv ====
// user direct/raw access engine
// one captured user access at a time, read data returned zero-extended
`timescale 1ns/1ns
`default_nettype none

module user_direct_engine
    import mif_ctrl_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire                     write,
    input  wire                     raw,
    input  uif_addr_t               addr,
    input  uif_data_t               wdata,
    output logic                    rsp_valid,
    output uif_data_t               rdata,
    dprio_req_if.requester          bus
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_ISSUE,
        D_WAIT
    } dir_state_t;

    dir_state_t  state;
    logic        write_q;
    logic        raw_q;
    dprio_addr_t addr_q;
    dprio_data_t wdata_q;

    assign req_ready = (state == D_IDLE);

    assign bus.req_valid = (state == D_ISSUE);
    assign bus.write     = write_q;
    assign bus.protect   = !raw_q;   // raw mode bypasses masking
    assign bus.addr      = addr_q;
    assign bus.wdata     = wdata_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= D_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (state == D_WAIT) && bus.rsp_valid;
            case (state)
                D_IDLE:  if (req_valid) state <= D_ISSUE;
                D_ISSUE: if (bus.req_ready) state <= D_WAIT;
                D_WAIT:  if (bus.rsp_valid) state <= D_IDLE;
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == D_IDLE) && req_valid) begin
            write_q <= write;
            raw_q   <= raw;
            addr_q  <= dprio_addr_t'(addr);
            wdata_q <= wdata[15:0];   // register space is 16 bits wide
        end
        if ((state == D_WAIT) && bus.rsp_valid) begin
            rdata <= uif_data_t'(bus.rdata);
        end
    end

endmodule

`default_nettype wire

// ==== tests/mif_reconfig_checker.sv ====
// protocol checker for the register space access unit
// request hold, go strobe spacing and response pairing
`timescale 1ns/1ns
`default_nettype none

module mif_reconfig_checker
    import mif_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         req_valid,
    input  wire         req_ready,
    input  wire         write,
    input  wire         protect,
    input  dprio_addr_t addr,
    input  dprio_data_t wdata,
    input  wire         rsp_valid,
    input  wire         dprio_go
);

    int unsigned fail_count = 0;
    logic        pending;   // request accepted, response not yet seen

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            pending <= 1'b1;
        end else if (rsp_valid) begin
            pending <= 1'b0;
        end
    end

    go_single: assert property (@(posedge clk) disable iff (reset) dprio_go |=> !dprio_go)
        else begin
            $error("dprio_go high on two consecutive cycles");
            fail_count++;
        end

    rsp_paired: assert property (@(posedge clk) disable iff (reset) rsp_valid |-> pending)
        else begin
            $error("rsp_valid with no request outstanding");
            fail_count++;
        end

    // requester must hold everything until the transfer
    req_hold: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable({write, protect, addr, wdata})))
        else begin
            $error("request changed before it was accepted");
            fail_count++;
        end

endmodule

bind dprio_rmw_access mif_reconfig_checker rmw_checker_inst (
    .clk(clk), .reset(reset), .req_valid(bus.req_valid), .req_ready(bus.req_ready),
    .write(bus.write), .protect(bus.protect), .addr(bus.addr), .wdata(bus.wdata),
    .rsp_valid(bus.rsp_valid), .dprio_go(dprio_go)
);

`default_nettype wire

// ==== tests/mif_reconfig_ctrl_tb.sv ====
// testbench for the MIF reconfiguration controller
// register space model with random wait states, user and MIF stimulus, scoreboard
`timescale 1ns/1ns
`default_nettype none

module mif_reconfig_ctrl_tb
    import mif_ctrl_pkg::*;
();

    localparam int WAIT_LIMIT = 300;   // cycles per handshake

    logic        clk, reset;
    logic        uif_valid, uif_ready, uif_write, uif_rsp_valid;
    mif_mode_t   uif_mode;
    uif_addr_t   uif_addr;
    uif_data_t   uif_wdata, uif_rdata;
    logic        mif_valid, mif_ready, mif_last, mif_start;
    dprio_addr_t mif_addr;
    dprio_data_t mif_data;
    mif_base_t   mif_base_addr;
    logic        dprio_go, dprio_write, dprio_wait;
    dprio_addr_t dprio_addr;
    dprio_data_t dprio_wdata, dprio_rdata;

    dprio_data_t mem [4096];      // register space model
    dprio_data_t shadow [4096];   // expected contents
    logic        m_busy;
    int          m_left;
    dprio_addr_t m_addr;

    uif_data_t   exp_q [$];
    bit          chk_q [$];
    uif_data_t   exp_word, last_rdata;
    bit          exp_chk;
    int          rsp_count, start_count;

    mif_reconfig_ctrl mif_reconfig_ctrl_inst (.*);

    always #50 clk = ~clk;

    function automatic dprio_data_t fill_word(input dprio_addr_t a);
        return {a[3:0], a} ^ 16'ha5c3;
    endfunction

    // masked bits come from the old word, the rest from the new one
    function automatic dprio_data_t ref_merge(input dprio_data_t old_word,
                                              input dprio_data_t new_word,
                                              input dprio_addr_t addr);
        dprio_data_t m;
        m = '0;
        for (int i = 0; i < RMW_NUM; i++) begin
            if (addr == RMW_ADDR[i]) m = RMW_MASK[i];
        end
        return (old_word & m) | (new_word & ~m);
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic run_error(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic value_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_uif_data(input uif_data_t got, input uif_data_t exp);
        if (got !== exp) value_error($sformatf("user data 0x%08h, expected 0x%08h", got, exp));
    endtask

    task automatic check_dprio_word(input dprio_addr_t a, input dprio_data_t exp);
        if (mem[a] !== exp) begin
            value_error($sformatf("register 0x%03h holds 0x%04h, expected 0x%04h",
                                  a, mem[a], exp));
        end
    endtask

    task automatic check_err(input mif_err_t got, input mif_err_t exp);
        if (got !== exp) value_error($sformatf("error status %b, expected %b", got, exp));
    endtask

    // register space model, go sampled mid-cycle, 0 to 3 wait cycles
    always @(negedge clk) begin
        if (m_busy) begin
            if (m_left == 0) begin
                dprio_wait  = 1'b0;
                dprio_rdata = mem[m_addr];   // access ends this cycle
                m_busy      = 1'b0;
            end else begin
                m_left--;
                dprio_wait = 1'b1;
            end
        end else if (dprio_go) begin
            m_addr = dprio_addr;
            if (dprio_write) mem[dprio_addr] = dprio_wdata;
            m_left     = $urandom % 4;
            m_busy     = 1'b1;
            dprio_wait = 1'b1;
        end
    end

    // compare every user response in order
    always @(posedge clk) begin
        if (!reset && uif_rsp_valid) begin
            if (exp_q.size() == 0) begin
                run_error("user port gave a response with no request outstanding");
            end else begin
                exp_word   = exp_q.pop_front();
                exp_chk    = chk_q.pop_front();
                last_rdata = uif_rdata;
                if (exp_chk) check_uif_data(uif_rdata, exp_word);
                rsp_count++;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && mif_start) start_count++;
    end

    always @(negedge clk) begin
        if (mif_reconfig_ctrl_inst.dprio_rmw_access_inst.rmw_checker_inst.fail_count != 0) begin
            run_error("a protocol assertion on the access unit failed");
        end
    end

    task automatic uif_access(input mif_mode_t mode, input logic wr, input uif_addr_t a,
                              input uif_data_t wd, input bit chk, input uif_data_t exp,
                              output uif_data_t rd);
        int n;
        int target;
        @(negedge clk);
        uif_valid = 1'b1;
        uif_write = wr;
        uif_mode  = mode;
        uif_addr  = a;
        uif_wdata = wd;
        n = 0;
        @(posedge clk);
        while (!uif_ready) begin
            n++;
            if (n > WAIT_LIMIT) run_error("user port did not accept a request in time");
            @(posedge clk);
        end
        exp_q.push_back(exp);
        chk_q.push_back(chk);
        target = rsp_count + 1;
        @(negedge clk);
        uif_valid = 1'b0;
        n = 0;
        while (rsp_count < target) begin
            n++;
            if (n > WAIT_LIMIT) run_error("user port gave no response in time");
            @(negedge clk);
        end
        if (mode == MODE_STREAM && n != 1) value_error("stream mode response not one cycle late");
        rd = last_rdata;
    endtask

    task automatic user_write(input mif_mode_t mode, input dprio_addr_t a, input uif_data_t wd);
        uif_data_t rd;
        if (mode == MODE_RAW) shadow[a] = wd[15:0];
        else shadow[a] = ref_merge(shadow[a], wd[15:0], a);
        uif_access(mode, 1'b1, uif_addr_t'(a), wd, 1'b0, '0, rd);
    endtask

    task automatic user_read(input mif_mode_t mode, input dprio_addr_t a);
        uif_data_t rd;
        uif_access(mode, 1'b0, uif_addr_t'(a), '0, 1'b1, uif_data_t'(shadow[a]), rd);
    endtask

    task automatic read_err(input mif_err_t exp);
        uif_data_t rd;
        uif_access(MODE_STREAM, 1'b0, REG_ERR_OFST, '0, 1'b0, '0, rd);
        check_err(mif_err_t'(rd), exp);
    endtask

    task automatic mif_send(input dprio_addr_t a, input dprio_data_t d, input logic last);
        int n;
        @(negedge clk);
        mif_valid = 1'b1;
        mif_addr  = a;
        mif_data  = d;
        mif_last  = last;
        n = 0;
        @(posedge clk);
        while (!mif_ready) begin
            n++;
            if (n > WAIT_LIMIT) run_error("MIF input did not accept a word in time");
            @(posedge clk);
        end
        @(negedge clk);
        mif_valid = 1'b0;
    endtask

    // stream words stay off 03A and 061, those belong to the direct traffic
    task automatic stream_word(input logic last);
        dprio_addr_t a;
        dprio_data_t d;
        if ($urandom % 2) begin
            a = RMW_ADDR[$urandom % 2];
        end else begin
            a = dprio_addr_t'(12'h200 + ($urandom % 64));
        end
        d = dprio_data_t'($urandom);
        shadow[a] = ref_merge(shadow[a], d, a);
        mif_send(a, d, last);
    endtask

    task automatic check_all_memory();
        for (int i = 0; i < 4096; i++) begin
            check_dprio_word(dprio_addr_t'(i), shadow[i]);
        end
    endtask

    initial begin
        uif_data_t rd;
        uif_data_t base;
        int        starts;
        void'($urandom(32'h58aa_1a76));
        clk         = 1'b0;
        reset       = 1'b1;
        uif_valid   = 1'b0;
        uif_write   = 1'b0;
        uif_mode    = MODE_STREAM;
        uif_addr    = '0;
        uif_wdata   = '0;
        mif_valid   = 1'b0;
        mif_addr    = '0;
        mif_data    = '0;
        mif_last    = 1'b0;
        dprio_wait  = 1'b1;
        dprio_rdata = '0;
        m_busy      = 1'b0;
        m_left      = 0;
        m_addr      = '0;
        rsp_count   = 0;
        start_count = 0;
        last_rdata  = '0;
        for (int i = 0; i < 4096; i++) begin
            mem[i]    = fill_word(dprio_addr_t'(i));
            shadow[i] = mem[i];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // base address write and readback
        base = $urandom;
        uif_access(MODE_STREAM, 1'b1, REG_BASE_OFST, base, 1'b0, '0, rd);
        check_uif_data(mif_base_addr, base);
        uif_access(MODE_STREAM, 1'b0, REG_BASE_OFST, '0, 1'b1, base, rd);
        uif_access(mif_mode_t'(2'd3), 1'b0, REG_BASE_OFST, '0, 1'b1, '0, rd);   // unused code

        // illegal offset reads zero, clear bit wipes the error
        uif_access(MODE_STREAM, 1'b0, 12'h005, '0, 1'b1, '0, rd);
        read_err(2'b01);
        uif_access(MODE_STREAM, 1'b1, REG_CTRL_OFST, 32'h2, 1'b0, '0, rd);
        read_err(2'b00);

        // raw access ignores the mask, every bit flips
        user_write(MODE_RAW, 12'h024, {16'h5a5a, ~shadow[12'h024]});
        check_dprio_word(12'h024, shadow[12'h024]);
        user_read(MODE_RAW, 12'h024);
        user_read(MODE_RAW, 12'h155);

        // direct writes, protected and plain
        user_write(MODE_DIRECT, 12'h03A, {16'h5a5a, ~shadow[12'h03A]});
        check_dprio_word(12'h03A, shadow[12'h03A]);
        user_write(MODE_DIRECT, 12'h155, $urandom);
        check_dprio_word(12'h155, shadow[12'h155]);

        // one stream, then a stray word once disarmed
        starts = start_count;
        uif_access(MODE_STREAM, 1'b1, REG_CTRL_OFST, 32'h1, 1'b0, '0, rd);
        if (start_count != starts + 1) value_error("mif_start did not pulse once");
        for (int i = 0; i < 8; i++) begin
            stream_word(i == 7);
        end
        mif_send(12'h2ff, 16'h0000, 1'b1);   // engine idle again
        read_err(2'b10);
        check_all_memory();
        uif_access(MODE_STREAM, 1'b1, REG_CTRL_OFST, 32'h2, 1'b0, '0, rd);

        // direct traffic competing with a stream
        uif_access(MODE_STREAM, 1'b1, REG_CTRL_OFST, 32'h1, 1'b0, '0, rd);
        fork
            begin
                for (int i = 0; i < 10; i++) begin
                    stream_word(i == 9);
                end
            end
            begin
                for (int i = 0; i < 6; i++) begin
                    user_write(MODE_DIRECT, RMW_ADDR[2 + i % 2], $urandom);
                    user_write(MODE_DIRECT, dprio_addr_t'(12'h400 + i), $urandom);
                    user_read(MODE_DIRECT, RMW_ADDR[2 + i % 2]);
                end
            end
        join
        mif_send(12'h2ff, 16'h0000, 1'b1);
        read_err(2'b10);
        check_all_memory();

        if (mif_reconfig_ctrl_inst.dprio_rmw_access_inst.rmw_checker_inst.fail_count != 0) begin
            run_error("a protocol assertion on the access unit failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
